// ==== src/settings_pkg.sv ====
`default_nettype none

package settings_pkg;

   // ==============================
   // settings bus
   // ==============================

   localparam int set_addr_w = 8;
   localparam int set_data_w = 32;

   // register offsets from the block base.
   localparam int addr_next_secs  = 0;
   localparam int addr_next_ticks = 1;
   localparam int addr_pps_polsrc = 2; // bit 0 is polarity, bit 1 is source.
   localparam int addr_pps_imm    = 3;
   localparam int addr_tps        = 4;

   // register widths.
   localparam int time_reg_w = 32;
   localparam int polsrc_w   = 2;
   localparam int imm_w      = 1;

endpackage

`default_nettype wire

// ==== src/time_pkg.sv ====
`default_nettype none

package time_pkg;

   // ==============================
   // time word
   // ==============================

   typedef struct packed {
      logic [31:0] seconds;
      logic [31:0] ticks;
   } vita_fields_t;

   // the link shifts the raw word, the counter works on the fields.
   typedef union packed {
      logic [63:0]  raw;
      vita_fields_t f;
   } vita_time_u;

   // ==============================
   // serial link
   // ==============================

   localparam int frame_bits = 65;   // one start bit and 64 data bits.
   localparam int link_latency = 66; // cycles from send_sync to sync_rcvd.

endpackage

`default_nettype wire

// ==== src/setting_reg.sv ====
`default_nettype none

module setting_reg
#(
   parameter logic [31:0] my_addr = 32'd0,
   parameter int width = 32,
   parameter logic [width-1:0] at_reset = '0
)
(
   input  wire logic                                 clk,
   input  wire logic                                 rst,
   input  wire logic                                 strobe,
   input  wire logic [settings_pkg::set_addr_w-1:0] addr,
   input  wire logic [settings_pkg::set_data_w-1:0] data,
   output logic [width-1:0]                          value,
   output logic                                      changed
);

   logic hit;

   assign hit = strobe && (addr == my_addr[settings_pkg::set_addr_w-1:0]);

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         value   <= at_reset;
         changed <= 1'b0;
      end
      else
      begin
         changed <= hit; // high in the cycle after the write.
         if (hit)
         begin
            value <= data[width-1:0];
         end
      end
   end

endmodule

`default_nettype wire

// ==== src/pps_capture.sv ====
`default_nettype none

module pps_capture
(
   input  wire logic clk,
   input  wire logic rst,
   input  wire logic pps,
   input  wire logic sync_rcvd,
   input  wire logic pps_polarity,
   input  wire logic pps_source,
   output logic      pps_edge
);

   logic       level;
   logic       pps_reg;
   logic [1:0] pps_hist;

   // polarity 1 means the pulse is active low.
   assign level = (pps_source ? sync_rcvd : pps) ^ pps_polarity;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         pps_reg  <= 1'b0;
         pps_hist <= 2'b00;
      end
      else
      begin
         pps_reg  <= level; // the only stage facing the pin.
         pps_hist <= {pps_hist[0], pps_reg};
      end
   end

   assign pps_edge = pps_hist[0] & ~pps_hist[1];

   // ==============================
   // checks
   // ==============================

   a_edge_single : assert property (
      @(posedge clk) disable iff (rst)
      pps_edge |=> !pps_edge
   );

endmodule

`default_nettype wire

// ==== src/time_counter.sv ====
`default_nettype none

module time_counter
(
   input  wire logic        clk,
   input  wire logic        rst,
   input  wire logic        arm,
   input  wire logic        set_imm,
   input  wire logic        pps_edge,
   input  wire logic [31:0] next_seconds,
   input  wire logic [31:0] next_ticks,
   input  wire logic [31:0] tps,
   output time_pkg::vita_time_u vita_time
);

   logic        armed;
   logic        load;
   logic [31:0] ticks_next;

   assign load       = armed & (set_imm | pps_edge);
   assign ticks_next = vita_time.f.ticks + 32'd1;

   // ==============================
   // arm flag
   // ==============================

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         armed <= 1'b0;
      end
      else if (arm)
      begin
         armed <= 1'b1; // a new preset waits for its trigger.
      end
      else if (load)
      begin
         armed <= 1'b0;
      end
   end

   // ==============================
   // seconds and ticks
   // ==============================

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         vita_time.raw <= 64'd0;
      end
      else if (load)
      begin
         vita_time.f.seconds <= next_seconds; // a load wins over rollover.
         vita_time.f.ticks   <= next_ticks;
      end
      else if (ticks_next == tps)
      begin
         vita_time.f.seconds <= vita_time.f.seconds + 32'd1;
         vita_time.f.ticks   <= 32'd0;
      end
      else
      begin
         vita_time.f.ticks <= ticks_next;
      end
   end

   // once in range the ticks stay in range until a load or a new tps.
   a_ticks_range : assert property (
      @(posedge clk) disable iff (rst)
      (!load && (vita_time.f.ticks < tps)) |=>
         (!$stable(tps) || (vita_time.f.ticks < tps))
   );

endmodule

`default_nettype wire

// ==== src/time_sender.sv ====
`default_nettype none

module time_sender
#(
   parameter int unsigned sync_rate = 59999
)
(
   input  wire logic     clk,
   input  wire logic     rst,
   input  time_pkg::vita_time_u vita_time,
   output logic          exp_time_out
);

   localparam int cnt_w = $clog2(sync_rate + 1);
   localparam int bit_w = $clog2(time_pkg::frame_bits);

   logic [cnt_w-1:0] interval;
   logic             send_sync;
   logic [bit_w-1:0] bits_left;
   logic [63:0]      shreg;

   if (sync_rate <= time_pkg::link_latency)
   begin : g_rate_check
      $error("sync_rate must be larger than the link latency.");
   end

   assign send_sync = (interval == cnt_w'(sync_rate));

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         interval     <= '0;
         bits_left    <= '0;
         exp_time_out <= 1'b0;
      end
      else if (send_sync)
      begin
         interval     <= '0;
         bits_left    <= bit_w'(time_pkg::frame_bits - 1);
         exp_time_out <= 1'b1; // start bit.
      end
      else
      begin
         interval     <= interval + 1'b1;
         exp_time_out <= (bits_left != '0) ? shreg[0] : 1'b0;
         if (bits_left != '0)
         begin
            bits_left <= bits_left - 1'b1;
         end
      end
   end

   // the word is taken in the send_sync cycle and sent lsb first.
   always_ff @(posedge clk)
   begin
      if (send_sync)
      begin
         shreg <= vita_time.raw;
      end
      else if (bits_left != '0)
      begin
         shreg <= {1'b0, shreg[63:1]};
      end
   end

   a_no_overlap : assert property (
      @(posedge clk) disable iff (rst)
      send_sync |-> (bits_left == '0)
   );

endmodule

`default_nettype wire

// ==== src/time_receiver.sv ====
`default_nettype none

module time_receiver
(
   input  wire logic     clk,
   input  wire logic     rst,
   input  wire logic     exp_time_in,
   output time_pkg::vita_time_u vita_time_rcvd,
   output logic          sync_rcvd
);

   localparam int data_bits = time_pkg::frame_bits - 1;
   localparam int bit_w = $clog2(time_pkg::frame_bits);

   logic [bit_w-1:0] bits_left;
   logic             busy;
   logic             last;
   logic [63:0]      shreg;
   logic [63:0]      word;

   assign busy = (bits_left != '0);
   assign last = (bits_left == bit_w'(1));
   assign word = {exp_time_in, shreg[63:1]}; // lsb arrives first.

   // ==============================
   // frame control
   // ==============================

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         bits_left <= '0;
         sync_rcvd <= 1'b0;
      end
      else
      begin
         sync_rcvd <= busy && last;
         if (!busy && exp_time_in)
         begin
            bits_left <= bit_w'(data_bits); // start bit seen.
         end
         else if (busy)
         begin
            bits_left <= bits_left - 1'b1;
         end
      end
   end

   // ==============================
   // data path
   // ==============================

   always_ff @(posedge clk)
   begin
      if (busy)
      begin
         shreg <= word;
      end
      if (busy && last)
      begin
         vita_time_rcvd.raw <= word; // updated together with sync_rcvd.
      end
   end

   a_rcvd_pulse : assert property (
      @(posedge clk) disable iff (rst)
      sync_rcvd |=> !sync_rcvd
   );

endmodule

`default_nettype wire

// ==== src/time_64bit.sv ====
`default_nettype none

module time_64bit
#(
   parameter int unsigned ticks_per_sec = 100000000,
   parameter int unsigned base = 0,
   parameter int unsigned sync_rate = 59999
)
(
   input  wire logic                                 clk,
   input  wire logic                                 rst,
   input  wire logic                                 set_stb,
   input  wire logic [settings_pkg::set_addr_w-1:0] set_addr,
   input  wire logic [settings_pkg::set_data_w-1:0] set_data,
   input  wire logic                                 pps,
   input  wire logic                                 exp_time_in,
   output wire logic [63:0]                          vita_time,
   output wire logic                                 pps_int,
   output wire logic                                 exp_time_out,
   output wire logic [63:0]                          vita_time_rcvd,
   output wire logic                                 sync_rcvd
);

   wire logic [31:0] next_seconds;
   wire logic [31:0] next_ticks;
   wire logic [31:0] tps;
   wire logic        arm;
   wire logic        pps_polarity;
   wire logic        pps_source;
   wire logic        set_imm;
   wire logic        pps_edge;

   // ==============================
   // settings registers
   // ==============================

   setting_reg #(.my_addr(base + settings_pkg::addr_next_secs),
                 .width(settings_pkg::time_reg_w)) sr_next_secs
      (.clk(clk), .rst(rst), .strobe(set_stb), .addr(set_addr), .data(set_data),
       .value(next_seconds), .changed(arm)); // writing the seconds arms the load.

   setting_reg #(.my_addr(base + settings_pkg::addr_next_ticks),
                 .width(settings_pkg::time_reg_w)) sr_next_ticks
      (.clk(clk), .rst(rst), .strobe(set_stb), .addr(set_addr), .data(set_data),
       .value(next_ticks), .changed());

   setting_reg #(.my_addr(base + settings_pkg::addr_pps_polsrc),
                 .width(settings_pkg::polsrc_w)) sr_pps_polsrc
      (.clk(clk), .rst(rst), .strobe(set_stb), .addr(set_addr), .data(set_data),
       .value({pps_source, pps_polarity}), .changed());

   setting_reg #(.my_addr(base + settings_pkg::addr_pps_imm),
                 .width(settings_pkg::imm_w)) sr_pps_imm
      (.clk(clk), .rst(rst), .strobe(set_stb), .addr(set_addr), .data(set_data),
       .value(set_imm), .changed());

   setting_reg #(.my_addr(base + settings_pkg::addr_tps),
                 .width(settings_pkg::time_reg_w),
                 .at_reset(ticks_per_sec)) sr_tps
      (.clk(clk), .rst(rst), .strobe(set_stb), .addr(set_addr), .data(set_data),
       .value(tps), .changed());

   // ==============================
   // time keeping and link
   // ==============================

   pps_capture u_pps_capture
      (.clk(clk), .rst(rst), .pps(pps), .sync_rcvd(sync_rcvd),
       .pps_polarity(pps_polarity), .pps_source(pps_source), .pps_edge(pps_edge));

   time_counter u_time_counter
      (.clk(clk), .rst(rst), .arm(arm), .set_imm(set_imm), .pps_edge(pps_edge),
       .next_seconds(next_seconds), .next_ticks(next_ticks), .tps(tps),
       .vita_time(vita_time));

   time_sender #(.sync_rate(sync_rate)) u_time_sender
      (.clk(clk), .rst(rst), .vita_time(vita_time), .exp_time_out(exp_time_out));

   time_receiver u_time_receiver
      (.clk(clk), .rst(rst), .exp_time_in(exp_time_in),
       .vita_time_rcvd(vita_time_rcvd), .sync_rcvd(sync_rcvd));

   assign pps_int = pps_edge;

endmodule

`default_nettype wire

// ==== bench/time_64bit_tb.sv ====
`default_nettype none

module time_64bit_tb;

   localparam int unsigned base = 0;
   localparam int unsigned ticks_per_sec = 1000;
   localparam int unsigned sync_rate = 199;
   localparam int first_rcvd = sync_rate + time_pkg::link_latency; // first sync_rcvd cycle.
   localparam int max_entries = 32;
   localparam int max_cycles = 2048;

   localparam logic [7:0] a_secs   = 8'(base + settings_pkg::addr_next_secs);
   localparam logic [7:0] a_ticks  = 8'(base + settings_pkg::addr_next_ticks);
   localparam logic [7:0] a_polsrc = 8'(base + settings_pkg::addr_pps_polsrc);
   localparam logic [7:0] a_imm    = 8'(base + settings_pkg::addr_pps_imm);
   localparam logic [7:0] a_tps    = 8'(base + settings_pkg::addr_tps);

   logic        clk;
   logic        rst;
   logic        set_stb;
   logic [7:0]  set_addr;
   logic [31:0] set_data;
   logic        pps;
   wire logic        link; // exp_time_out looped back to exp_time_in.
   wire logic [63:0] vita_time;
   wire logic        pps_int;
   wire logic [63:0] vita_time_rcvd;
   wire logic        sync_rcvd;

   // ==============================
   // stimulus table and model
   // ==============================

   string       tbl_name [max_entries];
   logic        tbl_set  [max_entries];
   logic [7:0]  tbl_addr [max_entries];
   logic [31:0] tbl_data [max_entries];
   logic        tbl_pps  [max_entries];
   int          tbl_wait [max_entries];
   logic [63:0] tbl_exp  [max_entries];
   int          n_entries = 0;

   logic [63:0] exp_time    [max_cycles];
   logic        exp_pps_int [max_cycles];
   logic        exp_sync    [max_cycles];
   logic        exp_link    [max_cycles]; // expected bit on the serial line.
   logic        lev         [max_cycles]; // selected, polarity-corrected pps level.
   int          ent_of      [max_cycles];
   int          total_cycles;
   int          timeout_limit;
   int          run_cycles = 0;
   int          cyc;

   time_64bit #(.ticks_per_sec(ticks_per_sec), .base(base), .sync_rate(sync_rate)) UUT
      (.clk(clk), .rst(rst), .set_stb(set_stb), .set_addr(set_addr), .set_data(set_data),
       .pps(pps), .exp_time_in(link), .vita_time(vita_time), .pps_int(pps_int),
       .exp_time_out(link), .vita_time_rcvd(vita_time_rcvd), .sync_rcvd(sync_rcvd));

   always #5 clk = ~clk;

   task automatic add_entry(input string name, input logic set, input logic [7:0] addr,
                            input logic [31:0] data, input logic pin, input int wait_cycles);
      tbl_name[n_entries] = name;
      tbl_set[n_entries]  = set;
      tbl_addr[n_entries] = addr;
      tbl_data[n_entries] = data;
      tbl_pps[n_entries]  = pin;
      tbl_wait[n_entries] = wait_cycles;
      n_entries++;
   endtask

   task automatic fill_table();
      add_entry("count", 0, 0, 0, 0, 5);
      add_entry("tps_10", 1, a_tps, 10, 0, 30);
      add_entry("imm_on", 1, a_imm, 1, 0, 2);
      add_entry("preset_ticks", 1, a_ticks, 5, 0, 2);
      add_entry("preset_secs_imm", 1, a_secs, 32'h100, 0, 3); // preset shows in S+3.
      add_entry("count_after_imm", 0, 0, 0, 0, 7);
      add_entry("imm_off", 1, a_imm, 0, 0, 2);
      add_entry("arm_pps", 1, a_secs, 32'h200, 0, 4);
      add_entry("pps_pulse", 0, 0, 0, 1, 1);
      add_entry("pps_load", 0, 0, 0, 0, 5);
      add_entry("pol_inverted", 1, a_polsrc, 1, 1, 6); // pin now idles high.
      add_entry("arm_inverted", 1, a_secs, 32'h300, 1, 4);
      add_entry("pps_low_pulse", 0, 0, 0, 0, 1);
      add_entry("inverted_load", 0, 0, 0, 1, 5);
      add_entry("tps_large", 1, a_tps, 32'h7fff_ffff, 1, 2);
      add_entry("pol_normal", 1, a_polsrc, 0, 0, 2);
      add_entry("loopback", 0, 0, 0, 0, 450);
      add_entry("src_sync", 1, a_polsrc, 2, 0, 2);
      add_entry("arm_sync", 1, a_secs, 32'h400, 0, 2);
      add_entry("sync_pps", 0, 0, 0, 1, 400); // pin held high and ignored.
   endtask

   // steps the timekeeper rules cycle by cycle over the whole table.
   task automatic build_model();
      logic [31:0] sec;
      logic [31:0] tick;
      logic [31:0] r_tps;
      logic [31:0] r_nsec;
      logic [31:0] r_ntick;
      logic        r_pol;
      logic        r_src;
      logic        r_imm;
      logic        armed;
      logic        arm;
      logic        load;
      logic        stb;
      logic        lv2;
      logic        lv3;
      int          c;
      int          ph;
      sec = 0;
      tick = 0;
      r_tps = ticks_per_sec;
      r_nsec = 0;
      r_ntick = 0;
      r_pol = 0;
      r_src = 0;
      r_imm = 0;
      armed = 0;
      arm = 0;
      c = 0;
      for (int e = 0; e < n_entries; e++)
      begin
         for (int k = 0; k < tbl_wait[e]; k++)
         begin
            stb = tbl_set[e] && (k == 0);
            ent_of[c] = e;
            exp_time[c] = {sec, tick};
            exp_sync[c] = (c >= first_rcvd) && ((c - first_rcvd) % (sync_rate + 1) == 0);
            ph = c - int'(sync_rate); // cycles since the first send_sync.
            if (ph >= 0)
            begin
               ph = ph % (int'(sync_rate) + 1);
            end
            if (ph == 1)
            begin
               exp_link[c] = 1'b1; // start bit.
            end
            else if (ph >= 2 && ph <= time_pkg::frame_bits)
            begin
               exp_link[c] = exp_time[c - ph][ph - 2];
            end
            else
            begin
               exp_link[c] = 1'b0;
            end
            lev[c] = (r_src ? exp_sync[c] : tbl_pps[e]) ^ r_pol;
            lv2 = (c >= 2) ? lev[c-2] : 1'b0;
            lv3 = (c >= 3) ? lev[c-3] : 1'b0;
            exp_pps_int[c] = lv2 && !lv3; // two cycles after the level first rises.
            load = armed && (r_imm || exp_pps_int[c]);
            if (load)
            begin
               sec = r_nsec;
               tick = r_ntick;
            end
            else if (tick + 32'd1 == r_tps)
            begin
               sec = sec + 32'd1;
               tick = 0;
            end
            else
            begin
               tick = tick + 32'd1;
            end
            armed = arm || (armed && !load);
            arm = stb && (tbl_addr[e] == a_secs);
            if (stb)
            begin
               case (tbl_addr[e])
                  a_secs:   r_nsec = tbl_data[e];
                  a_ticks:  r_ntick = tbl_data[e];
                  a_polsrc:
                  begin
                     r_pol = tbl_data[e][0];
                     r_src = tbl_data[e][1];
                  end
                  a_imm:    r_imm = tbl_data[e][0];
                  a_tps:    r_tps = tbl_data[e];
                  default:  ;
               endcase
            end
            c++;
         end
         tbl_exp[e] = {sec, tick};
      end
      total_cycles = c;
   endtask

   task automatic report_mismatch(input string test, input string what,
                                  input logic [63:0] expected, input logic [63:0] actual);
      $display("ERROR %s: %s expected %h, actual %h", test, what, expected, actual);
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic check_cycle(input int c);
      string name;
      name = tbl_name[ent_of[c]];
      assert (vita_time == exp_time[c])
         else report_mismatch(name, "vita_time", exp_time[c], vita_time);
      assert (pps_int == exp_pps_int[c])
         else report_mismatch(name, "pps_int", 64'(exp_pps_int[c]), 64'(pps_int));
      assert (link == exp_link[c])
         else report_mismatch(name, "exp_time_out", 64'(exp_link[c]), 64'(link));
      assert (sync_rcvd == exp_sync[c])
         else report_mismatch(name, "sync_rcvd", 64'(exp_sync[c]), 64'(sync_rcvd));
      if (exp_sync[c])
      begin
         assert (vita_time_rcvd == exp_time[c - time_pkg::link_latency])
            else report_mismatch(name, "vita_time_rcvd",
                                 exp_time[c - time_pkg::link_latency], vita_time_rcvd);
      end
   endtask

   // ==============================
   // run
   // ==============================

   initial
   begin
      clk      = 1'b0;
      rst      = 1'b1;
      set_stb  = 1'b0;
      set_addr = '0;
      set_data = '0;
      pps      = 1'b0;
      fill_table();
      build_model();
      timeout_limit = total_cycles + 500;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      cyc = 0; // vita_time is 0 in this cycle.
      for (int e = 0; e < n_entries; e++)
      begin
         for (int k = 0; k < tbl_wait[e]; k++)
         begin
            check_cycle(cyc);
            set_stb  = tbl_set[e] && (k == 0);
            set_addr = tbl_addr[e];
            set_data = tbl_data[e];
            pps      = tbl_pps[e];
            @(negedge clk);
            cyc++;
         end
         assert (vita_time == tbl_exp[e])
            else report_mismatch(tbl_name[e], "vita_time at end", tbl_exp[e], vita_time);
      end
      $display("Test passed");
      $finish;
   end

   always @(posedge clk)
   begin
      run_cycles++;
      if (run_cycles > timeout_limit)
      begin
         $display("Timeout: the run went past %0d cycles without finishing.", timeout_limit);
         $display("Test failed");
         $fatal(1);
      end
   end

endmodule

`default_nettype wire

// ==== list.f ====
src/settings_pkg.sv
src/time_pkg.sv
src/setting_reg.sv
src/pps_capture.sv
src/time_counter.sv
src/time_sender.sv
src/time_receiver.sv
src/time_64bit.sv
bench/time_64bit_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module time_64bit_tb -Mdir obj_dir -f list.f
	@out=$$(./obj_dir/Vtime_64bit_tb); echo "$$out"; echo "$$out" | grep -q "Test passed"

clean:
	rm -rf obj_dir
